// ==== hw/diag_pkg.sv ====
// ==============================
// Diagnostic counter and LED types
// PWM period is 2**PWM_BITS cycles
// ==============================
package diag_pkg;

	// LED duty factor, scaled by 4 against the PWM counter
	typedef logic [7:0] duty_t;

	// Packet category and its count
	typedef logic [3:0]  category_t;
	typedef logic [19:0] cat_count_t;

	// Wraps silently
	typedef logic [15:0] fault_count_t;

	// Advances once per PWM period
	typedef logic [31:0] uptime_t;

	// PWM counter width and derived values
	localparam int PWM_BITS = 10;
	typedef logic [PWM_BITS-1:0] pwm_count_t;
	// Shift from duty to PWM compare value
	localparam int DUTY_SHIFT = PWM_BITS - $bits(duty_t);

	// One counter per category
	localparam int NUM_CATEGORIES = 2 ** $bits(category_t);

endpackage

// ==== hw/lb_bus_pkg.sv ====
// ==============================
// Local bus types and address map
// 24-bit address and 32-bit data
// Read data returns 3 cycles after the strobe cycle
// ==============================
package lb_bus_pkg;

	// Bus widths
	typedef logic [23:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;

	// One request per strobe cycle
	// Read when strobe and rd are both high
	typedef struct packed {
		lb_addr_t addr;
		logic     strobe;
		logic     rd;
		lb_data_t wdata;
	} lb_req_t;

	// ==============================
	// Address map pages (addr[23:16])
	// ==============================
	localparam logic [7:0] REG_BANK_PAGE   = 8'h11;
	localparam logic [7:0] COUNTER_PAGE    = 8'h04;
	// Category counters also need addr[15:12] == 1
	localparam logic [3:0] COUNTER_SUBPAGE = 4'h1;
	localparam logic [7:0] MIRROR_PAGE     = 8'h00;
	localparam logic [7:0] WRITE_PAGE      = 8'h00;

	// Returned for unmapped reads
	localparam lb_data_t FILL_WORD = 32'hdeadbeef;

	// Mirror memory holds 2**MIRROR_AW words
	localparam int MIRROR_AW = 5;

	// ==============================
	// Register bank read indices
	// ==============================
	localparam logic [3:0] REG_IDX_HELLO_0 = 4'd0;
	localparam logic [3:0] REG_IDX_HELLO_1 = 4'd1;
	localparam logic [3:0] REG_IDX_HELLO_2 = 4'd2;
	localparam logic [3:0] REG_IDX_HELLO_3 = 4'd3;
	localparam logic [3:0] REG_IDX_FAULT   = 4'd4;
	localparam logic [3:0] REG_IDX_UPTIME  = 4'd5;
	localparam logic [3:0] REG_IDX_SCRATCH = 4'd6;

	// Greeting spells "Hello world!(::)"
	localparam lb_data_t GREETING_0 = "Hell";
	localparam lb_data_t GREETING_1 = "o wo";
	localparam lb_data_t GREETING_2 = "rld!";
	localparam lb_data_t GREETING_3 = "(::)";
	// Any other bank index
	localparam lb_data_t UNUSED_WORD = "zzzz";

	// Write indices within WRITE_PAGE
	localparam logic [3:0] WR_IDX_LED_USER = 4'd1;
	localparam logic [3:0] WR_IDX_DUTY1    = 4'd2;
	localparam logic [3:0] WR_IDX_DUTY2    = 4'd3;
	localparam logic [3:0] WR_IDX_SCRATCH  = 4'd7;

endpackage

// ==== hw/lb_demo_slave.sv ====
// ==============================
// Local bus demo slave
// Writes land on the next edge, reads return after 3 cycles
// Mirror aliases every write in WRITE_PAGE
// No back-pressure, one request per cycle
// ==============================
`timescale 1ns/100ps

module lb_demo_slave (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lb_bus_pkg::lb_req_t   req,
	output lb_bus_pkg::lb_data_t  rdata,
	input  logic                  fault,
	input  logic                  tick,
	input  lb_bus_pkg::lb_data_t  scratch_in,
	output lb_bus_pkg::lb_data_t  scratch_out,
	output logic                  led_user,
	output diag_pkg::duty_t       duty1,
	output diag_pkg::duty_t       duty2,
	output diag_pkg::category_t   cnt_addr,
	input  diag_pkg::cat_count_t  cnt_data
);
	import lb_bus_pkg::*;
	import diag_pkg::*;

	// Request qualifiers
	logic         do_rd;
	logic         wr_en;

	// Diagnostic state
	fault_count_t fault_cnt;
	uptime_t      uptime;
	lb_data_t     scratch_in_q;

	// Read pipeline
	logic         do_rd_q1;
	logic         do_rd_q2;
	lb_addr_t     addr_q;
	lb_data_t     bank_q;
	lb_data_t     stage2_q;
	logic         use_mirror_q;
	lb_data_t     mirror_q;

	assign do_rd = req.strobe & req.rd;
	assign wr_en = req.strobe & ~req.rd & (req.addr[23:16] == WRITE_PAGE);

	// Counter bank sees the raw address
	// Its registered output lines up with stage 2
	assign cnt_addr = category_t'(req.addr[3:0]);

	// ==============================
	// Diagnostics
	// ==============================

	// Fault count wraps at 16 bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_cnt <= '0;
		end else if (fault) begin
			fault_cnt <= fault_cnt + 1'b1;
		end
	end

	// Uptime in PWM periods
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uptime <= '0;
		end else if (tick) begin
			uptime <= uptime + 1'b1;
		end
	end

	// Scratch input gets one register before the read mux
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scratch_in_q <= '0;
		end else begin
			scratch_in_q <= scratch_in;
		end
	end

	// ==============================
	// Writes
	// ==============================

	// Only the low nibble selects the target
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_user    <= 1'b0;
			duty1       <= '0;
			duty2       <= '0;
			scratch_out <= '0;
		end else if (wr_en) begin
			case (req.addr[3:0])
				WR_IDX_LED_USER: led_user    <= req.wdata[0];
				WR_IDX_DUTY1:    duty1       <= duty_t'(req.wdata[7:0]);
				WR_IDX_DUTY2:    duty2       <= duty_t'(req.wdata[7:0]);
				WR_IDX_SCRATCH:  scratch_out <= req.wdata;
				default: ;
			endcase
		end
	end

	// Mirror takes every write in the page
	// Read address comes from stage 1 so output meets stage 3
	mirror_dpram i_mirror_dpram (
		.clk     (clk),
		.wr_addr (req.addr[MIRROR_AW-1:0]),
		.rd_addr (addr_q[MIRROR_AW-1:0]),
		.wdata   (req.wdata),
		.wen     (wr_en),
		.rdata   (mirror_q)
	);

	// ==============================
	// Read pipeline
	// ==============================

	// Strobe delay line and registered address
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			do_rd_q1 <= 1'b0;
			do_rd_q2 <= 1'b0;
			addr_q   <= '0;
		end else begin
			do_rd_q1 <= do_rd;
			do_rd_q2 <= do_rd_q1;
			addr_q   <= req.addr;
		end
	end

	// Stage 1
	// Select within the register bank
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (req.addr[3:0])
				REG_IDX_HELLO_0: bank_q <= GREETING_0;
				REG_IDX_HELLO_1: bank_q <= GREETING_1;
				REG_IDX_HELLO_2: bank_q <= GREETING_2;
				REG_IDX_HELLO_3: bank_q <= GREETING_3;
				REG_IDX_FAULT:   bank_q <= lb_data_t'(fault_cnt);
				REG_IDX_UPTIME:  bank_q <= lb_data_t'(uptime);
				REG_IDX_SCRATCH: bank_q <= scratch_in_q;
				default:         bank_q <= UNUSED_WORD;
			endcase
		end
	end

	// Stage 2
	// Page decode on the registered address
	always_ff @(posedge clk) begin
		if (do_rd_q1) begin
			if (addr_q[23:16] == REG_BANK_PAGE) begin
				stage2_q <= bank_q;
			end else if (addr_q[23:16] == COUNTER_PAGE &&
					addr_q[15:12] == COUNTER_SUBPAGE) begin
				stage2_q <= lb_data_t'(cnt_data);
			end else begin
				// Also covers the mirror page, overridden in stage 3
				stage2_q <= FILL_WORD;
			end
		end
	end

	// Stage 3 source flag is control state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			use_mirror_q <= 1'b0;
		end else if (do_rd_q1) begin
			use_mirror_q <= (addr_q[23:16] == MIRROR_PAGE);
		end
	end

	// Stage 3
	// Mirror or decoded result
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (do_rd_q2) begin
			rdata <= use_mirror_q ? mirror_q : stage2_q;
		end
	end

	// ==============================
	// Checks
	// ==============================

	// Strobe without a defined direction is a master bug
	a_rd_known: assert property (@(posedge clk) disable iff (!rst_n)
		req.strobe |-> !$isunknown(req.rd))
		else $error("Bus strobe with unknown rd flag");

	// Whole pipeline and mirror alignment
	a_rdata_known: assert property (@(posedge clk) disable iff (!rst_n)
		do_rd |-> ##3 !$isunknown(rdata))
		else $error("Read data unknown three cycles after read");

endmodule

// ==== hw/lb_demo_top.sv ====
// ==============================
// Local bus demo top level
// Single clock domain
// ==============================
`timescale 1ns/100ps

module lb_demo_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lb_bus_pkg::lb_req_t   req,
	output lb_bus_pkg::lb_data_t  rdata,
	input  logic                  fault,
	input  logic                  cat_stb,
	input  diag_pkg::category_t   cat,
	input  lb_bus_pkg::lb_data_t  scratch_in,
	output lb_bus_pkg::lb_data_t  scratch_out,
	output logic                  led_user,
	output logic                  led1,
	output logic                  led2
);
	import diag_pkg::*;

	// Slave to counter bank
	category_t  cnt_addr;
	cat_count_t cnt_data;

	// Slave to PWM and back
	duty_t      duty1;
	duty_t      duty2;
	logic       tick;

	// Bus decode and diagnostics
	lb_demo_slave i_lb_demo_slave (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.rdata       (rdata),
		.fault       (fault),
		.tick        (tick),
		.scratch_in  (scratch_in),
		.scratch_out (scratch_out),
		.led_user    (led_user),
		.duty1       (duty1),
		.duty2       (duty2),
		.cnt_addr    (cnt_addr),
		.cnt_data    (cnt_data)
	);

	// Packet category statistics
	multi_counter i_multi_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.inc       (cat_stb),
		.inc_addr  (cat),
		.read_addr (cnt_addr),
		.read_data (cnt_data)
	);

	// LED dimming and uptime tick
	led_pwm i_led_pwm (
		.clk   (clk),
		.rst_n (rst_n),
		.duty1 (duty1),
		.duty2 (duty2),
		.led1  (led1),
		.led2  (led2),
		.tick  (tick)
	);

endmodule

// ==== hw/led_pwm.sv ====
// ==============================
// Two-channel LED PWM
// Period is 1024 cycles
// LED high for duty*4 cycles per period
// ==============================
`timescale 1ns/100ps

module led_pwm (
	input  logic            clk,
	input  logic            rst_n,
	input  diag_pkg::duty_t duty1,
	input  diag_pkg::duty_t duty2,
	output logic            led1,
	output logic            led2,
	output logic            tick
);
	import diag_pkg::*;

	// Free-running period counter
	pwm_count_t cnt;
	// Last count before the counter wraps
	logic       wrap;
	// Compare thresholds
	pwm_count_t thresh1;
	pwm_count_t thresh2;

	// Duty scaled up to the counter range
	assign thresh1 = pwm_count_t'(duty1) << DUTY_SHIFT;
	assign thresh2 = pwm_count_t'(duty2) << DUTY_SHIFT;
	assign wrap    = &cnt;

	// Counter wraps every 2**PWM_BITS cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Registered LED outputs and period tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
			tick <= 1'b0;
		end else begin
			led1 <= (cnt < thresh1);
			led2 <= (cnt < thresh2);
			tick <= wrap;
		end
	end

endmodule

// ==== hw/mirror_dpram.sv ====
// ==============================
// 32-word mirror memory
// One write port and one registered read port
// Contents are undefined until written
// ==============================
`timescale 1ns/100ps

module mirror_dpram (
	input  logic                             clk,
	input  logic [lb_bus_pkg::MIRROR_AW-1:0] wr_addr,
	input  logic [lb_bus_pkg::MIRROR_AW-1:0] rd_addr,
	input  lb_bus_pkg::lb_data_t             wdata,
	input  logic                             wen,
	output lb_bus_pkg::lb_data_t             rdata
);
	import lb_bus_pkg::*;

	// Storage
	lb_data_t mem [2**MIRROR_AW];

	// Write side
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[wr_addr] <= wdata;
		end
	end

	// Read side, old data on a same-address collision
	always_ff @(posedge clk) begin
		rdata <= mem[rd_addr];
	end

endmodule

// ==== hw/multi_counter.sv ====
// ==============================
// Bank of packet category counters
// Counters wrap at 2**20
// Read data lags read_addr by one cycle
// ==============================
`timescale 1ns/100ps

module multi_counter (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   inc,
	input  diag_pkg::category_t    inc_addr,
	input  diag_pkg::category_t    read_addr,
	output diag_pkg::cat_count_t   read_data
);
	import diag_pkg::*;

	// Counter storage
	cat_count_t counts [NUM_CATEGORIES];

	// One increment per strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_CATEGORIES; i++) begin
				counts[i] <= '0;
			end
		end else if (inc) begin
			counts[inc_addr] <= counts[inc_addr] + 1'b1;
		end
	end

	// Registered read port
	// Sees the count before a same-cycle increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_data <= '0;
		end else begin
			read_data <= counts[read_addr];
		end
	end

	// A strobe must name a real category
	a_inc_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		inc |-> !$isunknown(inc_addr))
		else $error("Category strobe with unknown category");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the local bus demo regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module lb_demo_tb -o lb_demo_sim

output=$(./obj_dir/lb_demo_sim 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

// ==== testbench/lb_demo_tb.sv ====
// ==============================
// Testbench for the local bus demo top level
// Mirror words are written before they are read
// Read results are sampled 3 cycles after each read strobe
// ==============================
`timescale 1ns/100ps

module lb_demo_tb;
	import lb_bus_pkg::*;
	import diag_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int FAULT_PULSES = 37;
	localparam int LED_WINDOW   = 1024;
	localparam int UPTIME_GAP   = 50;
	localparam int PIPE_SLACK   = 8;
	localparam int DUTY1_VAL    = 64;
	localparam int DUTY2_VAL    = 0;
	localparam lb_data_t SCRATCH_IN_VAL = 32'h5ca7c411;

	// One bus transaction with its expected read value
	typedef struct {
		string    name;
		bit       is_write;
		lb_addr_t addr;
		lb_data_t wdata;
		lb_data_t expected;
		bit       exact;
	} entry_t;

	// Category stimulus, one strobe per cycle
	localparam int NUM_CAT = 20;
	localparam logic [3:0] CAT_SEQ [NUM_CAT] = '{4'd3, 4'd7, 4'd3, 4'd0, 4'd15,
		4'd3, 4'd9, 4'd7, 4'd1, 4'd3, 4'd12, 4'd15, 4'd0, 4'd3, 4'd5, 4'd7,
		4'd9, 4'd3, 4'd14, 4'd2};

	logic       clk = 1'b0;
	logic       rst_n;
	lb_req_t    req;
	lb_data_t   rdata;
	logic       fault;
	logic       cat_stb;
	category_t  cat;
	lb_data_t   scratch_in;
	lb_data_t   scratch_out;
	logic       led_user;
	logic       led1;
	logic       led2;

	entry_t     table_q[$];
	lb_data_t   captured[];
	int         pend_idx[$];
	int         pend_due[$];
	int         cur_idx;
	int         cycle = 0;
	int         cycle_limit = 1000000;
	int         n_checks = 0;
	int         n_errors = 0;
	lb_data_t   rng_state;
	lb_data_t   scratch_val;
	int         tally [16];

	lb_demo_top i_lb_demo_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.rdata       (rdata),
		.fault       (fault),
		.cat_stb     (cat_stb),
		.cat         (cat),
		.scratch_in  (scratch_in),
		.scratch_out (scratch_out),
		.led_user    (led_user),
		.led1        (led1),
		.led2        (led2)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// ==============================
	// Helpers
	// ==============================

	function automatic lb_data_t xorshift32(input lb_data_t state);
		lb_data_t x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic void add_read(string name, lb_addr_t addr, lb_data_t exp, bit exact);
		entry_t e;
		e = '{name, 1'b0, addr, 32'h0, exp, exact};
		table_q.push_back(e);
	endfunction

	function automatic void add_write(string name, lb_addr_t addr, lb_data_t wdata);
		entry_t e;
		e = '{name, 1'b1, addr, wdata, 32'h0, 1'b0};
		table_q.push_back(e);
	endfunction

	task automatic check_value(string name, lb_data_t expected, lb_data_t actual);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("FAILED %s expected %h actual %h", name, expected, actual);
		end else begin
			$display("ok     %s", name);
		end
	endtask

	// Back-to-back requests, then wait for every read to come back
	task automatic issue_entries(int first, int last);
		for (int i = first; i < last; i++) begin
			@(posedge clk);
			#1;
			cur_idx = i;
			req.addr = table_q[i].addr;
			req.strobe = 1'b1;
			req.rd = !table_q[i].is_write;
			req.wdata = table_q[i].wdata;
		end
		@(posedge clk);
		#1;
		req = '0;
		while (pend_idx.size() > 0) begin
			@(posedge clk);
		end
	endtask

	// ==============================
	// Read tracking and timeout
	// ==============================

	// Strobe seen at this edge returns two edges later
	always @(posedge clk) begin
		cycle++;
		if (req.strobe && req.rd) begin
			pend_idx.push_back(cur_idx);
			pend_due.push_back(cycle + 2);
		end
		if (cycle >= cycle_limit) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle);
			$display("Regression failed");
			$finish;
		end
	end

	// Sample half a cycle after rdata settles
	always @(negedge clk) begin : sample_rdata
		int idx;
		while (pend_due.size() > 0 && pend_due[0] == cycle) begin
			idx = pend_idx.pop_front();
			void'(pend_due.pop_front());
			captured[idx] = rdata;
			if (table_q[idx].exact) begin
				check_value(table_q[idx].name, table_q[idx].expected, rdata);
			end
		end
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin : main_seq
		int n_main;
		int led1_high;
		int led2_high;
		lb_data_t mirror_words [32];
		req = '0;
		fault = 1'b0;
		cat_stb = 1'b0;
		cat = '0;
		scratch_in = SCRATCH_IN_VAL;
		rst_n = 1'b0;
		cur_idx = 0;
		led1_high = 0;
		led2_high = 0;
		rng_state = 32'd14139;

		// Greeting, unused index and unmapped page
		add_read("greeting 0", 24'h110000, "Hell", 1'b1);
		add_read("greeting 1", 24'h110001, "o wo", 1'b1);
		add_read("greeting 2", 24'h110002, "rld!", 1'b1);
		add_read("greeting 3", 24'h110003, "(::)", 1'b1);
		add_read("unused index 12", 24'h11000c, "zzzz", 1'b1);
		add_read("unmapped page 0x22", 24'h220000, 32'hdeadbeef, 1'b1);
		// Mixed burst, results must come back in order
		add_read("burst greeting 3", 24'h110003, "(::)", 1'b1);
		add_read("burst unmapped", 24'h223456, 32'hdeadbeef, 1'b1);
		add_read("burst unused", 24'h11000f, "zzzz", 1'b1);
		add_read("burst greeting 0", 24'h110000, "Hell", 1'b1);

		// Mirror fill and readback
		for (int i = 0; i < 32; i++) begin
			rng_state = xorshift32(rng_state);
			mirror_words[i] = rng_state;
			add_write($sformatf("mirror wr %0d", i), 24'(i), rng_state);
		end
		for (int i = 0; i < 32; i++) begin
			add_read($sformatf("mirror %0d", i), 24'(i), mirror_words[i], 1'b1);
		end

		// Register writes, also seen through the mirror
		rng_state = xorshift32(rng_state);
		scratch_val = rng_state;
		add_write("led_user wr", 24'h000001, 32'h1);
		add_write("duty1 wr", 24'h000002, 32'(DUTY1_VAL));
		add_write("duty2 wr", 24'h000003, 32'(DUTY2_VAL));
		add_write("scratch wr", 24'h000007, scratch_val);
		add_read("mirror led_user", 24'h000001, 32'h1, 1'b1);
		add_read("mirror duty1", 24'h000002, 32'(DUTY1_VAL), 1'b1);
		add_read("mirror duty2", 24'h000003, 32'(DUTY2_VAL), 1'b1);
		add_read("mirror scratch", 24'h000007, scratch_val, 1'b1);
		add_read("scratch_in", 24'h110006, SCRATCH_IN_VAL, 1'b1);

		// Counter reads, tally taken from the category table
		add_read("fault count", 24'h110004, 32'(FAULT_PULSES), 1'b1);
		for (int k = 0; k < 16; k++) begin
			tally[k] = 0;
		end
		for (int i = 0; i < NUM_CAT; i++) begin
			tally[CAT_SEQ[i]]++;
		end
		for (int k = 0; k < 16; k++) begin
			add_read($sformatf("category %0d", k), 24'h041000 | 24'(k), 32'(tally[k]), 1'b1);
		end

		// Uptime values are only compared with each other
		n_main = table_q.size();
		add_read("uptime first", 24'h110005, 32'h0, 1'b0);
		add_read("uptime later", 24'h110005, 32'h0, 1'b0);
		captured = new[table_q.size()];
		cycle_limit = 2 * (table_q.size() + 3 * PIPE_SLACK + RESET_CYCLES +
			FAULT_PULSES + NUM_CAT + LED_WINDOW + UPTIME_GAP);

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Faults and category strobes run side by side
		for (int i = 0; i < FAULT_PULSES; i++) begin
			@(posedge clk);
			#1;
			fault = 1'b1;
			cat_stb = (i < NUM_CAT);
			cat = (i < NUM_CAT) ? CAT_SEQ[i] : 4'd0;
		end
		@(posedge clk);
		#1;
		fault = 1'b0;
		cat_stb = 1'b0;

		issue_entries(0, n_main);
		check_value("scratch_out", scratch_val, scratch_out);
		check_value("led_user", 32'h1, {31'b0, led_user});

		// One full PWM period
		repeat (LED_WINDOW) begin
			@(negedge clk);
			if (led1) led1_high++;
			if (led2) led2_high++;
		end
		check_value("led1 high cycles", 32'(DUTY1_VAL * 4), 32'(led1_high));
		check_value("led2 high cycles", 32'(DUTY2_VAL * 4), 32'(led2_high));

		issue_entries(n_main, n_main + 1);
		repeat (UPTIME_GAP) @(posedge clk);
		issue_entries(n_main + 1, n_main + 2);
		check_value("uptime nonzero", 32'h1, {31'b0, captured[n_main] != 32'h0});
		check_value("uptime not decreasing", 32'h1,
			{31'b0, captured[n_main + 1] >= captured[n_main]});

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/lb_bus_pkg.sv
hw/diag_pkg.sv
hw/multi_counter.sv
hw/mirror_dpram.sv
hw/led_pwm.sv
hw/lb_demo_slave.sv
hw/lb_demo_top.sv
testbench/lb_demo_tb.sv
